// File: hw/armPkg.sv
/*
 * Shared definitions for the single-cycle ARMv4 subset core
 * Word and field types, flag and control structs, and the
 * instruction field encodings used by the decoder and datapath
 */
`default_nettype none

package armPkg;

   typedef logic [31:0] word_t;      // Data word, address or instruction
   typedef logic [3:0]  regAddr_t;   // Register number
   typedef logic [3:0]  cond_t;      // Condition field Instr[31:28]
   typedef logic [1:0]  aluCtrl_t;   // ALU operation select
   typedef logic [1:0]  immSrc_t;    // Immediate format select

   // ALU status outputs, same order as CPSR N Z C V
   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } aluFlags_t;

   typedef struct packed {
      logic nz;                      // Enable for N and Z
      logic cv;                      // Enable for C and V
   } flagWrite_t;

   // Decoded controls, before condition gating
   typedef struct packed {
      logic       regSrcB;           // 1 selects rd as read port 2 (stores)
      logic       regSrcA;           // 1 selects R15 as read port 1 (branch)
      immSrc_t    immSrc;
      logic       aluSrc;            // 1 selects extended immediate
      logic       memToReg;          // Load data to rd
      aluCtrl_t   aluCtrl;
      logic       regW;
      logic       memW;
      logic       branch;
      logic       memStrobe;
      flagWrite_t flagW;
   } ctrl_t;

   // Op field Instr[27:26]
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory   = 2'b01;
   localparam logic [1:0] opBranch   = 2'b10;

   // Command field Instr[24:21]
   localparam logic [3:0] cmdAnd = 4'b0000;
   localparam logic [3:0] cmdSub = 4'b0010;
   localparam logic [3:0] cmdAdd = 4'b0100;
   localparam logic [3:0] cmdOrr = 4'b1100;

   localparam aluCtrl_t aluAdd = 2'b00;
   localparam aluCtrl_t aluSub = 2'b01;
   localparam aluCtrl_t aluAnd = 2'b10;
   localparam aluCtrl_t aluOrr = 2'b11;

   localparam immSrc_t immByte     = 2'b00;   // imm8, zero extended
   localparam immSrc_t immOffset12 = 2'b01;   // imm12, zero extended
   localparam immSrc_t immBranch24 = 2'b10;   // imm24, sign extended, x4

   // Condition codes
   localparam cond_t condEq = 4'h0;
   localparam cond_t condNe = 4'h1;
   localparam cond_t condCs = 4'h2;
   localparam cond_t condCc = 4'h3;
   localparam cond_t condMi = 4'h4;
   localparam cond_t condPl = 4'h5;
   localparam cond_t condVs = 4'h6;
   localparam cond_t condVc = 4'h7;
   localparam cond_t condHi = 4'h8;
   localparam cond_t condLs = 4'h9;
   localparam cond_t condGe = 4'hA;
   localparam cond_t condLt = 4'hB;
   localparam cond_t condGt = 4'hC;
   localparam cond_t condLe = 4'hD;
   localparam cond_t condAl = 4'hE;

   localparam regAddr_t pcReg = 4'hF;

endpackage

`default_nettype wire

// File: hw/alu.sv
/*
 * ALU: add, subtract, AND, OR
 * One 33-bit adder with conditionally inverted b; NZCV out,
 * C and V forced to zero for logic operations
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire armPkg::word_t    a,
   input  wire armPkg::word_t    b,
   input  wire armPkg::aluCtrl_t aluCtrl,
   output armPkg::word_t         y,
   output armPkg::aluFlags_t     flags
);

   logic          isSub;
   logic          isArith;
   armPkg::word_t bIn;
   logic [32:0]   sum;

   assign isSub   = (aluCtrl == armPkg::aluSub);
   assign isArith = (aluCtrl == armPkg::aluAdd) || isSub;
   assign bIn     = isSub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bIn} + {32'b0, isSub};  // a - b = a + ~b + 1

   always_comb
   begin
      case (aluCtrl)
         armPkg::aluAnd: y = a & b;
         armPkg::aluOrr: y = a | b;
         default:        y = sum[31:0];
      endcase
   end

   assign flags.neg   = y[31];
   assign flags.zero  = (y == '0);
   assign flags.carry = isArith & sum[32];   // ARM carry, no-borrow on SUB
   // Operands of equal sign (after inversion) with a different result sign
   assign flags.overflow = isArith & ~(a[31] ^ b[31] ^ isSub) & (a[31] ^ sum[31]);

endmodule

`default_nettype wire

// File: hw/regFile.sv
/*
 * Register file, R0 to R14
 * Two combinational reads, one write on the clock edge;
 * reads of register 15 return the supplied PC+8
 */
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             we,
   input  wire armPkg::regAddr_t ra1,
   input  wire armPkg::regAddr_t ra2,
   input  wire armPkg::regAddr_t wa,
   input  wire armPkg::word_t    wd,
   input  wire armPkg::word_t    r15,
   output armPkg::word_t         rd1,
   output armPkg::word_t         rd2
);

   armPkg::word_t regs [0:14];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 15; i++)
            regs[i] <= '0;                 // Known start state
      end
      else if (we && (wa != armPkg::pcReg))
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == armPkg::pcReg) ? r15 : regs[ra1];
   assign rd2 = (ra2 == armPkg::pcReg) ? r15 : regs[ra2];

endmodule

`default_nettype wire

// File: hw/execPath.sv
/*
 * Execute datapath
 * Read address select, immediate extension, ALU operand and
 * result select; result is written back to rd and used as branch target
 */
`timescale 1ns/1ps
`default_nettype none

module execPath (
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire armPkg::word_t instr,
   input  wire armPkg::ctrl_t ctrl,
   input  wire logic          regWrite,    // Already condition gated
   input  wire armPkg::word_t ReadData,
   input  wire armPkg::word_t pcPlus8,
   output armPkg::word_t      aluResult,
   output armPkg::word_t      writeData,
   output armPkg::word_t      result,
   output armPkg::aluFlags_t  aluFlags
);

   armPkg::regAddr_t ra1;
   armPkg::regAddr_t ra2;
   armPkg::word_t    srcA;
   armPkg::word_t    srcB;
   armPkg::word_t    extImm;

   assign ra1 = ctrl.regSrcA ? armPkg::pcReg : instr[19:16];  // rn or R15
   assign ra2 = ctrl.regSrcB ? instr[15:12] : instr[3:0];     // rd or rm

   regFile registers (
      .clk   (clk),
      .reset (reset),
      .we    (regWrite),
      .ra1   (ra1),
      .ra2   (ra2),
      .wa    (instr[15:12]),
      .wd    (result),
      .r15   (pcPlus8),
      .rd1   (srcA),
      .rd2   (writeData)                   // Also the store data
   );

   always_comb
   begin
      case (ctrl.immSrc)
         armPkg::immByte:     extImm = {24'b0, instr[7:0]};
         armPkg::immOffset12: extImm = {20'b0, instr[11:0]};
         armPkg::immBranch24: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
         default:             extImm = '0;
      endcase
   end

   assign srcB = ctrl.aluSrc ? extImm : writeData;

   alu arith (
      .a       (srcA),
      .b       (srcB),
      .aluCtrl (ctrl.aluCtrl),
      .y       (aluResult),
      .flags   (aluFlags)
   );

   assign result = ctrl.memToReg ? ReadData : aluResult;  // Load or ALU

endmodule

`default_nettype wire

// File: hw/pcUnit.sv
/*
 * Program counter unit
 * PC register with PCReady enable, next-PC select and PC+4/PC+8
 */
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
   parameter armPkg::word_t resetPc = '0
) (
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          PCReady,
   input  wire logic          pcSrc,       // Taken branch
   input  wire armPkg::word_t result,      // Branch target from datapath
   output armPkg::word_t      PC,
   output armPkg::word_t      pcPlus4,
   output armPkg::word_t      pcPlus8
);

   armPkg::word_t pcNext;

   assign pcPlus4 = PC + 32'd4;
   assign pcPlus8 = PC + 32'd8;            // What R15 reads as
   assign pcNext  = pcSrc ? result : pcPlus4;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         PC <= resetPc;
      else if (PCReady)                    // Stall holds the PC
         PC <= pcNext;
   end

endmodule

`default_nettype wire

// File: hw/condUnit.sv
/*
 * Condition unit
 * Holds NZCV, checks the condition field against it and gates
 * register, memory, flag and branch writes; PCReady low blocks commits
 */
`timescale 1ns/1ps
`default_nettype none

module condUnit (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire armPkg::cond_t     cond,
   input  wire armPkg::ctrl_t     ctrl,
   input  wire armPkg::aluFlags_t aluFlags,
   input  wire logic              PCReady,
   output logic                   regWrite,
   output logic                   memWrite,
   output logic                   pcSrc
);

   armPkg::aluFlags_t  flags;        // Stored NZCV
   armPkg::flagWrite_t flagWrite;
   logic               condEx;
   logic               commit;
   logic               ge;

   // Two halves with separate enables
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (flagWrite.nz)
         begin
            flags.neg  <= aluFlags.neg;
            flags.zero <= aluFlags.zero;
         end
         if (flagWrite.cv)
         begin
            flags.carry    <= aluFlags.carry;
            flags.overflow <= aluFlags.overflow;
         end
      end
   end

   assign ge = (flags.neg == flags.overflow);

   always_comb
   begin
      case (cond)
         armPkg::condEq: condEx = flags.zero;
         armPkg::condNe: condEx = !flags.zero;
         armPkg::condCs: condEx = flags.carry;
         armPkg::condCc: condEx = !flags.carry;
         armPkg::condMi: condEx = flags.neg;
         armPkg::condPl: condEx = !flags.neg;
         armPkg::condVs: condEx = flags.overflow;
         armPkg::condVc: condEx = !flags.overflow;
         armPkg::condHi: condEx = flags.carry && !flags.zero;
         armPkg::condLs: condEx = !flags.carry || flags.zero;
         armPkg::condGe: condEx = ge;
         armPkg::condLt: condEx = !ge;
         armPkg::condGt: condEx = !flags.zero && ge;
         armPkg::condLe: condEx = flags.zero || !ge;
         armPkg::condAl: condEx = 1'b1;
         default:        condEx = 1'b0;    // 1111 space, treated as no-op
      endcase
   end

   // Passed condition, not stalled and not in reset
   assign commit = condEx & PCReady & ~reset;

   assign flagWrite = ctrl.flagW & {2{commit}};
   assign regWrite  = ctrl.regW & commit;
   assign memWrite  = ctrl.memW & commit;  // Held low during stall and reset
   assign pcSrc     = ctrl.branch & condEx; // PC enable handles the stall

endmodule

`default_nettype wire

// File: hw/instrDecoder.sv
/*
 * Instruction decoder
 * Main decode of the op field plus ALU decode of the command field;
 * anything outside the supported subset decodes as a no-op
 */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  wire armPkg::word_t instr,
   output armPkg::ctrl_t      ctrl
);

   logic [1:0]       op;
   logic [5:0]       funct;
   logic [3:0]       cmd;
   armPkg::regAddr_t rd;
   armPkg::aluCtrl_t dpAlu;
   logic             cmdValid;
   logic             isArith;

   assign op    = instr[27:26];
   assign funct = instr[25:20];       // I, cmd, S
   assign cmd   = funct[4:1];
   assign rd    = instr[15:12];

   // ALU decode for data processing
   always_comb
   begin
      cmdValid = 1'b1;
      case (cmd)
         armPkg::cmdAdd: dpAlu = armPkg::aluAdd;
         armPkg::cmdSub: dpAlu = armPkg::aluSub;
         armPkg::cmdAnd: dpAlu = armPkg::aluAnd;
         armPkg::cmdOrr: dpAlu = armPkg::aluOrr;
         default:
         begin
            dpAlu    = armPkg::aluAdd;
            cmdValid = 1'b0;          // CMP, ADC, shifts etc. unsupported
         end
      endcase
   end

   // C and V only meaningful for ADD/SUB
   assign isArith = (dpAlu == armPkg::aluAdd) || (dpAlu == armPkg::aluSub);

   always_comb
   begin
      ctrl = '0;                      // No-op by default
      case (op)
         armPkg::opDataProc:
         if (cmdValid)
         begin
            ctrl.immSrc   = armPkg::immByte;
            ctrl.aluSrc   = funct[5];     // I bit
            ctrl.aluCtrl  = dpAlu;
            ctrl.regW     = 1'b1;
            ctrl.flagW.nz = funct[0];     // S bit
            ctrl.flagW.cv = funct[0] & isArith;
         end
         armPkg::opMemory:
         if (!funct[5])                   // Immediate offset form only
         begin
            ctrl.immSrc    = armPkg::immOffset12;
            ctrl.aluSrc    = 1'b1;
            ctrl.aluCtrl   = armPkg::aluAdd;  // rn + imm12
            ctrl.memStrobe = 1'b1;
            if (funct[0])                 // L bit, LDR
            begin
               ctrl.memToReg = 1'b1;
               ctrl.regW     = 1'b1;
            end
            else
            begin
               ctrl.regSrcB = 1'b1;       // Store data from rd
               ctrl.memW    = 1'b1;
            end
         end
         armPkg::opBranch:
         if (funct[5] && !funct[4])       // B only, BL dropped
         begin
            ctrl.regSrcA = 1'b1;          // Base is R15 = PC+8
            ctrl.immSrc  = armPkg::immBranch24;
            ctrl.aluSrc  = 1'b1;
            ctrl.aluCtrl = armPkg::aluAdd;
            ctrl.branch  = 1'b1;
         end
         default: ctrl = '0;
      endcase
      if (rd == armPkg::pcReg)
         ctrl.regW = 1'b0;                // Writes to R15 are ignored
   end

endmodule

`default_nettype wire

// File: hw/armCore.sv
/*
 * Single-cycle ARMv4 subset core
 * Decoder, condition unit, PC unit and datapath wired together;
 * memory outputs settle in the cycle the instruction is presented
 */
`timescale 1ns/1ps
`default_nettype none

module armCore #(
   parameter armPkg::word_t resetPc = '0
) (
   input  wire logic          clk,
   input  wire logic          reset,
   output armPkg::word_t      PC,
   input  wire armPkg::word_t Instr,
   input  wire armPkg::word_t ReadData,
   input  wire logic          PCReady,       // High commits this cycle
   output armPkg::word_t      ALUResult,
   output armPkg::word_t      WriteData,
   output logic               MemWrite,
   output logic               MemStrobe
);

   armPkg::ctrl_t     ctrl;
   armPkg::aluFlags_t aluFlags;
   armPkg::word_t     result;
   armPkg::word_t     pcPlus8;
   logic              regWrite;
   logic              pcSrc;

   instrDecoder decoder (
      .instr (Instr),
      .ctrl  (ctrl)
   );

   condUnit conditions (
      .clk      (clk),
      .reset    (reset),
      .cond     (Instr[31:28]),
      .ctrl     (ctrl),
      .aluFlags (aluFlags),
      .PCReady  (PCReady),
      .regWrite (regWrite),
      .memWrite (MemWrite),
      .pcSrc    (pcSrc)
   );

   pcUnit #(
      .resetPc (resetPc)
   ) programCounter (
      .clk     (clk),
      .reset   (reset),
      .PCReady (PCReady),
      .pcSrc   (pcSrc),
      .result  (result),
      .PC      (PC),
      .pcPlus4 (),                        // Only needed inside the PC unit
      .pcPlus8 (pcPlus8)
   );

   execPath datapath (
      .clk       (clk),
      .reset     (reset),
      .instr     (Instr),
      .ctrl      (ctrl),
      .regWrite  (regWrite),
      .ReadData  (ReadData),
      .pcPlus8   (pcPlus8),
      .aluResult (ALUResult),
      .writeData (WriteData),
      .result    (result),
      .aluFlags  (aluFlags)
   );

   assign MemStrobe = ctrl.memStrobe;     // Any LDR/STR, before condition

endmodule

`default_nettype wire

// File: test/armCore_asserts.sv
/*
 * Bound checks for armCore
 * Store strobe pairing, no stores in reset or stall, PC alignment
 */
`timescale 1ns/1ps
`default_nettype none

module armCoreAsserts (
   input wire logic          clk,
   input wire logic          reset,
   input wire logic          PCReady,
   input wire logic          MemWrite,
   input wire logic          MemStrobe,
   input wire armPkg::word_t PC
);

   int failCount = 0;                       // Read back by the testbench

   // A store is always a memory access
   memWriteHasStrobe: assert property (@(posedge clk) MemWrite |-> MemStrobe)
   else
   begin
      failCount++;
      $error("MemWrite high without MemStrobe");
   end

   // No store may leave the core in reset or while stalled
   noWriteWhenBlocked: assert property (@(posedge clk) (reset || !PCReady) |-> !MemWrite)
   else
   begin
      failCount++;
      $error("MemWrite high during reset or stall");
   end

   pcWordAligned: assert property (@(posedge clk) disable iff (reset) PC[1:0] == 2'b00)
   else
   begin
      failCount++;
      $error("PC not word aligned");
   end

endmodule

bind armCore armCoreAsserts coreChecks (
   .clk       (clk),
   .reset     (reset),
   .PCReady   (PCReady),
   .MemWrite  (MemWrite),
   .MemStrobe (MemStrobe),
   .PC        (PC)
);

`default_nettype wire

// File: test/armCoreTb.sv
/*
 * Testbench for the single-cycle ARMv4 subset core
 * Table of instructions with expected bus outputs, one row per cycle;
 * covers ALU ops, loads and stores, conditions, branches and stalls
 */
`timescale 1ns/1ps
`default_nettype none

module armCoreTb;

   localparam int            period      = 100;
   localparam int            resetCycles = 16;
   localparam armPkg::word_t resetPc     = '0;
   localparam armPkg::word_t nopInstr    = 32'hE1A0_0000;  // MOV, decodes as no-op
   localparam logic [1:0]    careNone    = 2'b00;
   localparam logic [1:0]    careAlu     = 2'b10;
   localparam logic [1:0]    careBoth    = 2'b11;

   // One table row: stimulus, then expected outputs
   typedef struct packed {
      armPkg::word_t instr;
      armPkg::word_t readData;
      logic          ready;
      armPkg::word_t pc;
      logic          memWrite;
      logic          memStrobe;
      armPkg::word_t aluResult;
      armPkg::word_t writeData;
      logic [1:0]    care;                  // {ALUResult, WriteData} checked
   } row_t;

   logic          clk = 1'b0;
   logic          reset;
   armPkg::word_t PC;
   armPkg::word_t Instr;
   armPkg::word_t ReadData;
   logic          PCReady;
   armPkg::word_t ALUResult;
   armPkg::word_t WriteData;
   logic          MemWrite;
   logic          MemStrobe;

   row_t rows[$];
   int   errorCount = 0;
   int   rowIdx     = -1;                   // -1 while in reset
   logic tableReady = 1'b0;

   always #(period / 2) clk = ~clk;

   armCore #(
      .resetPc (resetPc)
   ) DUT (
      .clk       (clk),
      .reset     (reset),
      .PC        (PC),
      .Instr     (Instr),
      .ReadData  (ReadData),
      .PCReady   (PCReady),
      .ALUResult (ALUResult),
      .WriteData (WriteData),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe)
   );

   // Instruction encoders
   function automatic armPkg::word_t dataProcImm(armPkg::cond_t cond, logic [3:0] cmd,
      logic s, armPkg::regAddr_t rn, armPkg::regAddr_t rd, logic [7:0] imm);
      return {cond, 2'b00, 1'b1, cmd, s, rn, rd, 4'h0, imm};
   endfunction

   function automatic armPkg::word_t dataProcReg(armPkg::cond_t cond, logic [3:0] cmd,
      logic s, armPkg::regAddr_t rn, armPkg::regAddr_t rd, armPkg::regAddr_t rm);
      return {cond, 2'b00, 1'b0, cmd, s, rn, rd, 8'h00, rm};
   endfunction

   // P=1 U=1 B=0 W=0, immediate offset
   function automatic armPkg::word_t memAccess(armPkg::cond_t cond, logic load,
      armPkg::regAddr_t rn, armPkg::regAddr_t rd, logic [11:0] offset);
      return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, offset};
   endfunction

   function automatic armPkg::word_t branchTo(armPkg::cond_t cond, logic [23:0] offset);
      return {cond, 3'b101, 1'b0, offset};
   endfunction

   task automatic addRow(armPkg::word_t instr, armPkg::word_t readData, logic ready,
      armPkg::word_t pc, logic memWrite, logic memStrobe, armPkg::word_t aluResult,
      armPkg::word_t writeData, logic [1:0] care);
      rows.push_back(row_t'{instr, readData, ready, pc, memWrite, memStrobe,
                            aluResult, writeData, care});
   endtask

   task automatic buildTable();
      logic [7:0]    a;
      logic [7:0]    b;
      logic [7:0]    c;
      logic [7:0]    d;
      logic [7:0]    e;
      logic [11:0]   off1;
      logic [11:0]   off2;
      armPkg::word_t loadVal;
      armPkg::word_t sum;
      armPkg::word_t andVal;
      armPkg::word_t orVal;
      armPkg::word_t pc;
      armPkg::word_t target;
      int            back;
      a       = 8'($urandom);
      b       = 8'($urandom);
      c       = 8'($urandom);
      d       = 8'($urandom) | 8'h01;       // Nonzero, so differs from reset r8
      e       = d ^ 8'h5A;                  // Differs from d
      off1    = 12'($urandom);
      off2    = 12'($urandom);
      loadVal = $urandom;
      sum     = 32'(a) + 32'(b);
      andVal  = sum & 32'(c);
      orVal   = andVal | 32'(a);
      back    = -5;
      pc      = resetPc;
      // r1 = a, r2 = a + b, r3 = b, r4 = r2 & c, r5 = r4 | r1
      addRow(dataProcImm(armPkg::condAl, armPkg::cmdAdd, 0, 0, 1, a), 0, 1, pc, 0, 0,
             32'(a), 0, careAlu);
      pc += 4;
      addRow(dataProcImm(armPkg::condAl, armPkg::cmdAdd, 0, 1, 2, b), 0, 1, pc, 0, 0,
             sum, 0, careAlu);
      pc += 4;
      addRow(dataProcReg(armPkg::condAl, armPkg::cmdSub, 0, 2, 3, 1), 0, 1, pc, 0, 0,
             32'(b), 0, careAlu);
      pc += 4;
      addRow(dataProcImm(armPkg::condAl, armPkg::cmdAnd, 0, 2, 4, c), 0, 1, pc, 0, 0,
             andVal, 0, careAlu);
      pc += 4;
      addRow(dataProcReg(armPkg::condAl, armPkg::cmdOrr, 0, 4, 5, 1), 0, 1, pc, 0, 0,
             orVal, 0, careAlu);
      pc += 4;
      // STR r5, LDR r6, STR r6 shows the loaded word
      addRow(memAccess(armPkg::condAl, 0, 1, 5, off1), 0, 1, pc, 1, 1,
             32'(a) + 32'(off1), orVal, careBoth);
      pc += 4;
      addRow(memAccess(armPkg::condAl, 1, 2, 6, off2), loadVal, 1, pc, 0, 1,
             sum + 32'(off2), 0, careAlu);
      pc += 4;
      addRow(memAccess(armPkg::condAl, 0, 0, 6, 12'h010), 0, 1, pc, 1, 1,
             32'h10, loadVal, careBoth);
      pc += 4;
      // SUBS r7, r1, r1 sets Z, C; N = V = 0
      addRow(dataProcReg(armPkg::condAl, armPkg::cmdSub, 1, 1, 7, 1), 0, 1, pc, 0, 0,
             0, 0, careAlu);
      pc += 4;
      addRow(dataProcImm(armPkg::condEq, armPkg::cmdAdd, 0, 0, 8, d), 0, 1, pc, 0, 0,
             32'(d), 0, careAlu);
      pc += 4;
      addRow(dataProcImm(armPkg::condNe, armPkg::cmdAdd, 0, 0, 8, e), 0, 1, pc, 0, 0,
             32'(e), 0, careAlu);           // Skipped, r8 keeps d
      pc += 4;
      addRow(memAccess(armPkg::condAl, 0, 0, 8, 12'h000), 0, 1, pc, 1, 1,
             0, 32'(d), careBoth);
      pc += 4;
      addRow(memAccess(armPkg::condNe, 0, 0, 8, 12'h004), 0, 1, pc, 0, 1,
             32'h4, 32'(d), careBoth);
      pc += 4;
      addRow(memAccess(armPkg::condGe, 0, 0, 8, 12'h008), 0, 1, pc, 1, 1,
             32'h8, 32'(d), careBoth);      // N == V, so GE passes
      pc += 4;
      // Forward, backward, then a BNE that falls through
      target = pc + 32'd8 + 32'd12;
      addRow(branchTo(armPkg::condAl, 24'd3), 0, 1, pc, 0, 0, target, 0, careAlu);
      pc = target;
      target = pc + 32'd8 + 32'(back * 4);
      addRow(branchTo(armPkg::condAl, 24'(back)), 0, 1, pc, 0, 0, target, 0, careAlu);
      pc = target;
      addRow(branchTo(armPkg::condNe, 24'd100), 0, 1, pc, 0, 0,
             pc + 32'd8 + 32'd400, 0, careAlu);
      pc += 4;
      // Store held two cycles by PCReady, then issued once
      addRow(memAccess(armPkg::condAl, 0, 0, 1, 12'h004), 0, 0, pc, 0, 1,
             32'h4, 32'(a), careBoth);
      addRow(memAccess(armPkg::condAl, 0, 0, 1, 12'h004), 0, 0, pc, 0, 1,
             32'h4, 32'(a), careBoth);
      addRow(memAccess(armPkg::condAl, 0, 0, 1, 12'h004), 0, 1, pc, 1, 1,
             32'h4, 32'(a), careBoth);
      pc += 4;
      addRow(nopInstr, 0, 1, pc, 0, 0, 0, 0, careNone);
   endtask

   task automatic abortRun(string why);
      $display("TEST FAIL");
      $fatal(1, why);
   endtask

   task automatic checkWord(string name, armPkg::word_t got, armPkg::word_t exp);
      assert (got === exp)
      else
      begin
         errorCount++;
         $display("[ERROR] %s: got %h, expected %h (row %0d)", name, got, exp, rowIdx);
         abortRun("Output mismatch");
      end
   endtask

   task automatic checkRow(row_t r);
      checkWord("PC", PC, r.pc);
      checkWord("MemWrite", 32'(MemWrite), 32'(r.memWrite));
      checkWord("MemStrobe", 32'(MemStrobe), 32'(r.memStrobe));
      if (r.care[1])
         checkWord("ALUResult", ALUResult, r.aluResult);
      if (r.care[0])
         checkWord("WriteData", WriteData, r.writeData);
   endtask

   // Watchdog sized from reset, table length and some slack
   initial
   begin
      wait (tableReady);
      #((resetCycles + rows.size() + 20) * period);
      $display("Timeout: the run did not complete in the expected time");
      abortRun("Watchdog expired");
   end

   initial
   begin
      reset    = 1'b1;
      Instr    = memAccess(armPkg::condAl, 0, 0, 0, 12'h000);  // Store held off by reset
      ReadData = '0;
      PCReady  = 1'b1;
      void'($urandom(32'hdedd));
      buildTable();
      tableReady = 1'b1;
      repeat (resetCycles)
      begin
         @(negedge clk);
         checkWord("PC", PC, resetPc);      // Held at resetPc
         checkWord("MemWrite", 32'(MemWrite), 32'h0);
      end
      reset = 1'b0;                         // Released on a falling edge
      for (int i = 0; i < rows.size(); i++)
      begin
         rowIdx   = i;
         Instr    = rows[i].instr;
         ReadData = rows[i].readData;
         PCReady  = rows[i].ready;
         #(period / 4);                     // Combinational outputs settled
         checkRow(rows[i]);
         @(negedge clk);
      end
      errorCount += DUT.coreChecks.failCount;
      if (errorCount == 0)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
         abortRun("Bound assertions reported failures");
   end

endmodule

`default_nettype wire

// File: build.f
hw/armPkg.sv
hw/alu.sv
hw/regFile.sv
hw/execPath.sv
hw/pcUnit.sv
hw/condUnit.sv
hw/instrDecoder.sv
hw/armCore.sv
test/armCore_asserts.sv
test/armCoreTb.sv
